/* Bender.yml */
package:
  name: udp_stream

export_include_dirs:
  - source

sources:
  - files:
      - source/udp_stream_pkg.sv
      - source/udp_send_timer.sv
      - source/udp_header_builder.sv
      - source/udp_payload_pattern.sv
      - source/udp_frame_streamer.sv
      - source/udp_stream_top.sv
  - target: test
    files:
      - bench/udp_stream_tb.sv

/* bench/udp_stream_input.txt */
# One test per line, delay and beats in decimal, all other fields in hex
# name delay dst_mac src_ip dst_ip src_port dst_port ip_checksum beats
basic          400 0A1B2C3D4E5F C0A8010A C0A80114 1388 1389 F460 134
fast_trigger    50 FFFFFFFFFFFF 0A000001 0A000002 0400 0401 63CD 134
disabled         0 112233445566 0A000001 0A000002 0001 0002 0000 0
wide_addr      300 FEDCBA987654 FFFFFFFE AC10FE01 FFFF 8000 CDBE 134
zero_addr      140 000000000000 00000000 00000000 0000 0000 77D0 134
back_to_back     1 020000000001 0A000001 0A000002 D431 0035 63CD 134

/* bench/udp_stream_tb.sv */
`timescale 1ns/10ps
`include "udp_stream_settings.svh"

module udp_stream_tb;

    import udp_stream_pkg::*;

    localparam int MAX_TESTS = 16;
    localparam int FRAMES_PER_TEST = 3;
    localparam int IDLE_WINDOW = 1000;
    localparam int PAYLOAD_LEN = 2 * `UDP_PAYLOAD_SHORTS;   // Payload bytes
    localparam int FRAME_LEN = 42 + PAYLOAD_LEN;
    localparam int BEATS = (FRAME_LEN + 7) / 8;
    localparam int TAIL_BYTES = 8 - (8 * BEATS - FRAME_LEN);
    localparam logic [47:0] SRC_MAC = 48'h001A2B3C4D5E;

    logic        m00_axis_aclk;
    logic        m00_axis_aresetn;
    udp_cfg_t    cfg;
    udp_cfg_t    cfg_next;   // Applied after the next rising edge
    logic        m00_axis_tvalid;
    logic        m00_axis_tready;
    logic [63:0] m00_axis_tdata;
    logic [7:0]  m00_axis_tkeep;
    logic        m00_axis_tlast;
    logic [31:0] sent_count;

    string       test_name [MAX_TESTS];
    udp_cfg_t    test_cfg [MAX_TESTS];
    logic [15:0] test_csum [MAX_TESTS];
    int          test_beats [MAX_TESTS];
    int          num_tests;
    string       cur_name;
    int          cur_beats;

    logic [7:0]  rx_bytes [8*BEATS];
    logic [7:0]  exp_hdr [42];
    int          beat_cnt;
    int          frames_done;
    int          first_beats;   // First-beat transfers since reset
    logic        after_last;
    logic        prev_valid;
    logic        prev_ready;
    logic [63:0] prev_data;
    logic [7:0]  prev_keep;
    logic        prev_last;
    logic [7:0]  tail_keep;
    longint      cycle_count;
    longint      cycle_limit;

    udp_stream_top udp_stream_top_i (
        .m00_axis_aclk    (m00_axis_aclk),
        .m00_axis_aresetn (m00_axis_aresetn),
        .cfg              (cfg),
        .m00_axis_tvalid  (m00_axis_tvalid),
        .m00_axis_tready  (m00_axis_tready),
        .m00_axis_tdata   (m00_axis_tdata),
        .m00_axis_tkeep   (m00_axis_tkeep),
        .m00_axis_tlast   (m00_axis_tlast),
        .sent_count       (sent_count)
    );

    initial begin
        m00_axis_aclk = 1'b0;
        forever #2 m00_axis_aclk = ~m00_axis_aclk;
    end

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(posedge m00_axis_aclk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            fail_run($sformatf("Timeout: no progress within %0d cycles", cycle_limit));
        end
    end

    task automatic check_value(string what, logic [63:0] expected, logic [63:0] actual);
        assert (expected == actual) else fail_run($sformatf(
            "MISMATCH %s %s expected %0h actual %0h", cur_name, what, expected, actual));
    endtask

    function automatic logic [7:0] tail_keep_mask();
        logic [7:0] mask;
        mask = 8'h00;
        for (int lane = 0; lane < TAIL_BYTES; lane++) begin
            mask[lane] = 1'b1;
        end
        return mask;
    endfunction

    // Header bytes in wire order
    task automatic build_expected_header(udp_cfg_t c, logic [15:0] csum);
        logic [335:0] hdr;
        hdr = {c.dst_mac, SRC_MAC, 16'h0800,
               8'h45, 8'h00, 16'(28 + PAYLOAD_LEN), 16'h0001,
               16'h4000, 8'd255, 8'd17, csum,   // DF, TTL, UDP
               c.src_ip, c.dst_ip, c.src_port, c.dst_port,
               16'(8 + PAYLOAD_LEN), 16'h0000};
        for (int i = 0; i < 42; i++) begin
            exp_hdr[i] = hdr[335 - 8*i -: 8];
        end
    endtask

    function automatic logic [15:0] payload_word(int k);
        if (k % 2 == 0) begin
            return 16'(k / 2);
        end
        return 16'(255 - (k - 1) / 2);   // Odd words count down
    endfunction

    function automatic logic [7:0] expected_byte(int n);
        logic [15:0] w;
        if (n < 42) begin
            return exp_hdr[n];
        end
        w = payload_word((n - 42) / 2);
        return ((n - 42) % 2) ? w[15:8] : w[7:0];   // Low byte first
    endfunction

    task automatic check_frame();
        for (int n = 0; n < FRAME_LEN; n++) begin
            check_value($sformatf("frame byte %0d", n), expected_byte(n), rx_bytes[n]);
        end
    endtask

    // Sampled at the falling edge, the transfer happens at the next rising edge
    task automatic observe_beat();
        logic       is_last;
        logic [7:0] want_keep;
        check_value("sent_count", first_beats, sent_count);
        if (prev_valid && !prev_ready) begin
            assert (m00_axis_tvalid) else fail_run($sformatf(
                "%s: tvalid dropped while the beat was stalled", cur_name));
            check_value("stalled tdata", prev_data, m00_axis_tdata);
            check_value("stalled tkeep", prev_keep, m00_axis_tkeep);
            check_value("stalled tlast", prev_last, m00_axis_tlast);
        end
        if (after_last) begin
            assert (!m00_axis_tvalid) else fail_run($sformatf(
                "%s: a new frame followed tlast without a fresh trigger", cur_name));
            after_last = 1'b0;
        end
        if (m00_axis_tvalid && m00_axis_tready) begin
            is_last   = (beat_cnt == cur_beats - 1);
            want_keep = is_last ? tail_keep : 8'hFF;
            if (beat_cnt == 0) begin
                first_beats++;
            end
            check_value($sformatf("tkeep beat %0d", beat_cnt), want_keep, m00_axis_tkeep);
            check_value($sformatf("tlast beat %0d", beat_cnt), is_last, m00_axis_tlast);
            for (int lane = 0; lane < 8; lane++) begin
                if (m00_axis_tkeep[lane]) begin
                    rx_bytes[8*beat_cnt + lane] = m00_axis_tdata[8*lane +: 8];
                end
            end
            if (is_last) begin
                check_frame();
                frames_done++;
                beat_cnt   = 0;
                after_last = 1'b1;
            end else begin
                beat_cnt++;
            end
        end
        prev_valid = m00_axis_tvalid;
        prev_ready = m00_axis_tready;
        prev_data  = m00_axis_tdata;
        prev_keep  = m00_axis_tkeep;
        prev_last  = m00_axis_tlast;
    endtask

    task automatic step_cycle();
        @(posedge m00_axis_aclk);
        #1;
        cfg             = cfg_next;
        m00_axis_tready = ($urandom % 3) != 0;   // Back-pressure a third of the time
        @(negedge m00_axis_aclk);
        observe_beat();
    endtask

    task automatic collect_frames();
        frames_done = 0;
        while (frames_done < FRAMES_PER_TEST) begin
            step_cycle();
        end
    endtask

    // Stop the timer and let a frame in flight finish
    task automatic drain_frames();
        int idle;
        idle = 0;
        cfg_next.packet_delay = 32'd0;
        while (idle < 4) begin
            step_cycle();
            idle = m00_axis_tvalid ? 0 : idle + 1;
        end
    endtask

    task automatic watch_idle_window();
        logic [31:0] start_count;
        start_count = sent_count;
        repeat (IDLE_WINDOW) begin
            step_cycle();
            assert (!m00_axis_tvalid) else fail_run($sformatf(
                "%s: a frame appeared while the timer was disabled", cur_name));
        end
        check_value("sent_count after idle window", start_count, sent_count);
    endtask

    task automatic read_vectors();
        int          fd;
        int          n;
        string       line;
        string       name;
        int          delay;
        logic [47:0] mac;
        logic [31:0] sip;
        logic [31:0] dip;
        logic [15:0] sp;
        logic [15:0] dp;
        logic [15:0] cs;
        int          beats;
        fd = $fopen("bench/udp_stream_input.txt", "r");
        if (fd == 0) begin
            fail_run("Cannot open bench/udp_stream_input.txt");
        end
        num_tests = 0;
        while (!$feof(fd) && num_tests < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%s %d %h %h %h %h %h %h %d",
                        name, delay, mac, sip, dip, sp, dp, cs, beats);
            if (n == 9) begin   // Comment and blank lines fall through
                test_name[num_tests]  = name;
                test_cfg[num_tests]   = '{32'(delay), mac, sip, dip, sp, dp};
                test_csum[num_tests]  = cs;
                test_beats[num_tests] = beats;
                num_tests++;
            end
        end
        $fclose(fd);
    endtask

    task automatic set_cycle_limit();
        longint delay;
        cycle_limit = 1000;
        for (int t = 0; t < num_tests; t++) begin
            delay = test_cfg[t].packet_delay;
            if (delay == 0) begin
                cycle_limit += IDLE_WINDOW + 100;
            end else begin
                cycle_limit += FRAMES_PER_TEST * (delay + 1 + 3 * BEATS) + 3 * BEATS + 50;
            end
        end
    endtask

    initial begin
        m00_axis_aresetn = 1'b0;
        m00_axis_tready  = 1'b0;
        cfg              = '0;
        cfg_next         = '0;
        cycle_count      = 0;
        cycle_limit      = 64'h7FFF_FFFF_FFFF;
        beat_cnt         = 0;
        frames_done      = 0;
        first_beats      = 0;
        after_last       = 1'b0;
        prev_valid       = 1'b0;
        prev_ready       = 1'b0;
        prev_last        = 1'b0;
        prev_data = '0;
        prev_keep = '0;
        cur_name  = "reset";
        cur_beats = BEATS;
        tail_keep = tail_keep_mask();
        void'($urandom(96));
        read_vectors();
        set_cycle_limit();
        repeat (10) @(posedge m00_axis_aclk);
        #1;
        m00_axis_aresetn = 1'b1;
        for (int t = 0; t < num_tests; t++) begin
            cur_name  = test_name[t];
            cur_beats = test_beats[t];
            cfg_next  = test_cfg[t];
            if (test_cfg[t].packet_delay == 32'd0) begin
                watch_idle_window();
            end else begin
                build_expected_header(test_cfg[t], test_csum[t]);
                collect_frames();
                drain_frames();
            end
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* compile.f */
+incdir+source
source/udp_stream_pkg.sv
source/udp_send_timer.sv
source/udp_header_builder.sv
source/udp_payload_pattern.sv
source/udp_frame_streamer.sv
source/udp_stream_top.sv
bench/udp_stream_tb.sv

/* source/udp_frame_streamer.sv */
`timescale 1ns/10ps

module udp_frame_streamer (
    input  logic                        m00_axis_aclk,
    input  logic                        m00_axis_aresetn,
    input  udp_stream_pkg::udp_header_t header,
    input  logic                        frame_start,
    output logic                        busy,
    output logic                        m00_axis_tvalid,
    input  logic                        m00_axis_tready,
    output logic [63:0]                 m00_axis_tdata,
    output logic [7:0]                  m00_axis_tkeep,
    output logic                        m00_axis_tlast,
    output logic [31:0]                 sent_count
);

    import udp_stream_pkg::*;

    // Header padded out to whole beats
    localparam int HDR_BEATS = (HEADER_BYTES + 7) / 8;
    localparam int HDR_PAD_W = HDR_BEATS * 64;
    localparam beat_idx_t LAST_BEAT = beat_idx_t'(FRAME_BEATS - 1);

    beat_idx_t            beat;
    logic                 xfer;
    logic                 last_beat;
    logic [HDR_PAD_W-1:0] hdr_bits;
    logic [63:0]          header_lanes;
    logic [63:0]          payload_bytes;

    assign xfer      = m00_axis_tvalid && m00_axis_tready;
    assign last_beat = (beat == LAST_BEAT);

    assign hdr_bits = {header, {(HDR_PAD_W - $bits(udp_header_t)){1'b0}}};

    // Byte n of the frame sits on lane n mod 8
    always_comb begin
        header_lanes = 64'd0;
        if (beat < beat_idx_t'(HDR_BEATS)) begin
            for (int lane = 0; lane < 8; lane++) begin
                header_lanes[8*lane +: 8] =
                    hdr_bits[HDR_PAD_W - 1 - 64 * int'(beat) - 8 * lane -: 8];
            end
        end
    end

    udp_payload_pattern payload_i (
        .beat          (beat),
        .payload_bytes (payload_bytes)
    );

    // Padding and payload are zero where the other applies, beat 5 holds both
    assign m00_axis_tdata = header_lanes | payload_bytes;

    always_comb begin
        if (!m00_axis_tvalid) begin
            m00_axis_tkeep = 8'h00;
        end else if (last_beat) begin
            m00_axis_tkeep = LAST_KEEP;
        end else begin
            m00_axis_tkeep = 8'hFF;
        end
    end

    assign m00_axis_tlast = m00_axis_tvalid && last_beat;
    assign busy           = m00_axis_tvalid;   // Released by the final transfer

    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            m00_axis_tvalid <= 1'b0;
            beat            <= '0;
        end else if (frame_start) begin
            m00_axis_tvalid <= 1'b1;
            beat            <= '0;
        end else if (xfer) begin
            if (last_beat) begin
                m00_axis_tvalid <= 1'b0;
                beat            <= '0;
            end else begin
                beat <= beat + beat_idx_t'(1);
            end
        end
    end

    // Count on the first beat of each frame
    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            sent_count <= 32'd0;
        end else if (xfer && beat == '0) begin
            sent_count <= sent_count + 32'd1;
        end
    end

endmodule

/* source/udp_header_builder.sv */
`timescale 1ns/10ps
`include "udp_stream_settings.svh"

module udp_header_builder (
    input  logic                        m00_axis_aclk,
    input  logic                        m00_axis_aresetn,
    input  udp_stream_pkg::udp_cfg_t    cfg,
    input  logic                        send_trigger,
    input  logic                        busy,
    output udp_stream_pkg::udp_header_t header,
    output logic                        frame_start
);

    import udp_stream_pkg::*;

    localparam logic [15:0] IP_TOTAL_LEN = 16'(28 + 2 * PAYLOAD_SHORTS);
    localparam logic [15:0] UDP_LEN = 16'(8 + 2 * PAYLOAD_SHORTS);

    udp_header_t base_header;   // Checksum field still zero
    logic [15:0] ip_words [10];
    logic [19:0] word_sum;
    logic [16:0] fold_once;
    logic [15:0] fold_twice;
    logic [15:0] ip_checksum;
    logic        accept;

    // Frame in flight or just launched, so drop the trigger
    assign accept = send_trigger && !busy && !frame_start;

    always_comb begin
        base_header.eth_dst       = cfg.dst_mac;
        base_header.eth_src       = `UDP_SRC_MAC;
        base_header.eth_type      = `UDP_ETH_TYPE;
        base_header.ip_ver_ihl    = `UDP_IP_VER_IHL;
        base_header.ip_tos        = `UDP_IP_TOS;
        base_header.ip_total_len  = IP_TOTAL_LEN;
        base_header.ip_id         = `UDP_IP_ID;
        base_header.ip_flags_frag = `UDP_IP_FLAGS_FRAG;
        base_header.ip_ttl        = `UDP_IP_TTL;
        base_header.ip_proto      = `UDP_IP_PROTO;
        base_header.ip_checksum   = 16'h0000;
        base_header.ip_src        = cfg.src_ip;
        base_header.ip_dst        = cfg.dst_ip;
        base_header.udp_src_port  = cfg.src_port;
        base_header.udp_dst_port  = cfg.dst_port;
        base_header.udp_len       = UDP_LEN;
        base_header.udp_checksum  = `UDP_CHECKSUM;
    end

    // The ten IPv4 header words
    assign ip_words[0] = {base_header.ip_ver_ihl, base_header.ip_tos};
    assign ip_words[1] = base_header.ip_total_len;
    assign ip_words[2] = base_header.ip_id;
    assign ip_words[3] = base_header.ip_flags_frag;
    assign ip_words[4] = {base_header.ip_ttl, base_header.ip_proto};
    assign ip_words[5] = base_header.ip_checksum;
    assign ip_words[6] = base_header.ip_src[31:16];
    assign ip_words[7] = base_header.ip_src[15:0];
    assign ip_words[8] = base_header.ip_dst[31:16];
    assign ip_words[9] = base_header.ip_dst[15:0];

    always_comb begin
        word_sum = 20'd0;
        for (int i = 0; i < 10; i++) begin
            word_sum = word_sum + 20'(ip_words[i]);
        end
    end

    // End-around carry, two folds are always enough here
    assign fold_once   = 17'(word_sum[15:0]) + 17'(word_sum[19:16]);
    assign fold_twice  = fold_once[15:0] + 16'(fold_once[16]);
    assign ip_checksum = ~fold_twice;

    always_ff @(posedge m00_axis_aclk) begin
        if (accept) begin
            header             <= base_header;
            header.ip_checksum <= ip_checksum;
        end
    end

    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            frame_start <= 1'b0;
        end else begin
            frame_start <= accept;
        end
    end

endmodule

/* source/udp_payload_pattern.sv */
`timescale 1ns/10ps

module udp_payload_pattern (
    input  udp_stream_pkg::beat_idx_t beat,
    output logic [63:0]               payload_bytes
);

    import udp_stream_pkg::*;

    int          byte_pos;
    int          word_idx;
    logic [15:0] pair_idx;
    logic [15:0] word_val;

    always_comb begin
        payload_bytes = 64'd0;
        for (int lane = 0; lane < 8; lane++) begin
            byte_pos = 8 * int'(beat) + lane - HEADER_BYTES;   // Offset into payload
            word_idx = byte_pos >>> 1;
            pair_idx = 16'(word_idx >>> 1);
            // Even words count up, odd words count down from 255
            if (word_idx[0]) begin
                word_val = 16'd255 - pair_idx;
            end else begin
                word_val = pair_idx;
            end
            if (byte_pos >= 0 && byte_pos < 2 * PAYLOAD_SHORTS) begin
                payload_bytes[8*lane +: 8] = byte_pos[0] ? word_val[15:8] : word_val[7:0];
            end
        end
    end

endmodule

/* source/udp_send_timer.sv */
`timescale 1ns/10ps

module udp_send_timer (
    input  logic        m00_axis_aclk,
    input  logic        m00_axis_aresetn,
    input  logic [31:0] packet_delay,
    output logic        send_trigger
);

    logic [31:0] count;
    logic        disabled;
    logic        expired;

    assign disabled = (packet_delay == 32'd0);

    // Also catches a delay lowered below the running count
    assign expired = (count >= packet_delay);

    // One trigger every packet_delay+1 cycles
    always_ff @(posedge m00_axis_aclk or negedge m00_axis_aresetn) begin
        if (!m00_axis_aresetn) begin
            count        <= 32'd0;
            send_trigger <= 1'b0;
        end else if (disabled) begin
            count        <= 32'd0;   // Hold idle
            send_trigger <= 1'b0;
        end else if (expired) begin
            count        <= 32'd0;
            send_trigger <= 1'b1;
        end else begin
            count        <= count + 32'd1;
            send_trigger <= 1'b0;
        end
    end

endmodule

/* source/udp_stream_pkg.sv */
`include "udp_stream_settings.svh"

package udp_stream_pkg;

    // Addressing and timing configuration, sampled at each trigger
    typedef struct packed {
        logic [31:0] packet_delay;  // Zero disables the timer
        logic [47:0] dst_mac;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
    } udp_cfg_t;

    // The 42 header bytes, first field goes out first
    typedef struct packed {
        logic [47:0] eth_dst;
        logic [47:0] eth_src;
        logic [15:0] eth_type;
        logic [7:0]  ip_ver_ihl;
        logic [7:0]  ip_tos;
        logic [15:0] ip_total_len;
        logic [15:0] ip_id;
        logic [15:0] ip_flags_frag;
        logic [7:0]  ip_ttl;
        logic [7:0]  ip_proto;
        logic [15:0] ip_checksum;
        logic [31:0] ip_src;
        logic [31:0] ip_dst;
        logic [15:0] udp_src_port;
        logic [15:0] udp_dst_port;
        logic [15:0] udp_len;
        logic [15:0] udp_checksum;
    } udp_header_t;

    localparam int PAYLOAD_SHORTS = `UDP_PAYLOAD_SHORTS;
    localparam int HEADER_BYTES = 42;
    localparam int FRAME_BYTES = HEADER_BYTES + 2 * PAYLOAD_SHORTS;
    localparam int FRAME_BEATS = (FRAME_BYTES + 7) / 8;

    // Bytes carried by the final beat, 1 to 8
    localparam int LAST_BYTES = FRAME_BYTES - 8 * (FRAME_BEATS - 1);
    localparam logic [7:0] LAST_KEEP = 8'((9'd1 << LAST_BYTES) - 9'd1);

    localparam int BEAT_W = $clog2(FRAME_BEATS + 1);
    typedef logic [BEAT_W-1:0] beat_idx_t;

endpackage

/* source/udp_stream_settings.svh */
`ifndef UDP_STREAM_SETTINGS_SVH
`define UDP_STREAM_SETTINGS_SVH

// Payload size in 16-bit words
`define UDP_PAYLOAD_SHORTS 512

// Ethernet fields not taken from the configuration
`define UDP_SRC_MAC 48'h001A2B3C4D5E
`define UDP_ETH_TYPE 16'h0800

// IPv4 fixed fields
`define UDP_IP_VER_IHL 8'h45     // Version 4, five-word header
`define UDP_IP_TOS 8'h00
`define UDP_IP_ID 16'd1
`define UDP_IP_FLAGS_FRAG 16'h4000 // Don't fragment
`define UDP_IP_TTL 8'd255
`define UDP_IP_PROTO 8'd17

// UDP checksum left unused
`define UDP_CHECKSUM 16'h0000

`endif

/* source/udp_stream_top.sv */
`timescale 1ns/10ps

module udp_stream_top (
    input  logic                     m00_axis_aclk,
    input  logic                     m00_axis_aresetn,
    input  udp_stream_pkg::udp_cfg_t cfg,
    output logic                     m00_axis_tvalid,
    input  logic                     m00_axis_tready,
    output logic [63:0]              m00_axis_tdata,
    output logic [7:0]               m00_axis_tkeep,
    output logic                     m00_axis_tlast,
    output logic [31:0]              sent_count
);

    import udp_stream_pkg::*;

    logic        send_trigger;
    udp_header_t header;
    logic        frame_start;
    logic        busy;

    udp_send_timer timer_i (
        .m00_axis_aclk    (m00_axis_aclk),
        .m00_axis_aresetn (m00_axis_aresetn),
        .packet_delay     (cfg.packet_delay),
        .send_trigger     (send_trigger)
    );

    // Header is captured once per frame
    udp_header_builder builder_i (
        .m00_axis_aclk    (m00_axis_aclk),
        .m00_axis_aresetn (m00_axis_aresetn),
        .cfg              (cfg),
        .send_trigger     (send_trigger),
        .busy             (busy),
        .header           (header),
        .frame_start      (frame_start)
    );

    udp_frame_streamer streamer_i (
        .m00_axis_aclk    (m00_axis_aclk),
        .m00_axis_aresetn (m00_axis_aresetn),
        .header           (header),
        .frame_start      (frame_start),
        .busy             (busy),
        .m00_axis_tvalid  (m00_axis_tvalid),
        .m00_axis_tready  (m00_axis_tready),
        .m00_axis_tdata   (m00_axis_tdata),
        .m00_axis_tkeep   (m00_axis_tkeep),
        .m00_axis_tlast   (m00_axis_tlast),
        .sent_count       (sent_count)
    );

endmodule
